// File: hw/cm_pkg.sv
// ----------------------------------------
// control memory layout for the block-end unit
// the PC splits into a group index and low bits
// modules take their default widths from here
// ----------------------------------------

package cm_pkg;

    // width of the program counter and of branch targets
    localparam int PC_WIDTH    = 8;

    // low PC bits compared with the match value, log2 of the group size
    localparam int LSB_WIDTH   = 3;

    // the upper PC bits address the control memory, one entry per group
    localparam int GROUP_WIDTH = PC_WIDTH - LSB_WIDTH;

    typedef logic [PC_WIDTH-1:0]    pc_t;
    typedef logic [LSB_WIDTH-1:0]   lsb_t;
    typedef logic [GROUP_WIDTH-1:0] group_t;

endpackage

// File: hw/pipe_pkg.sv
// ----------------------------------------
// pipeline stage numbers of the fetch unit
// shared by the RTL and the testbench model
// ----------------------------------------

package pipe_pkg;

    // match value and registered PC bits meet here
    localparam int MATCH_STAGE  = 1;

    // stages that carry the early and the final block-end flag
    localparam int EARLY_STAGE  = 2;
    localparam int FINAL_STAGE  = 3;

    // depth of the flag line from the compare to the early flag
    localparam int EARLY_DELAY  = FINAL_STAGE - MATCH_STAGE - 1;

    // the target leaves the control memory in the match stage
    // and has to wait until the final flag
    localparam int TARGET_DELAY = FINAL_STAGE - MATCH_STAGE;

endpackage

// File: hw/delay_line.sv
// ----------------------------------------
// fixed-depth register chain for any payload
// set DEPTH and payload_t at the instance
// ----------------------------------------

`timescale 1ns/1ps

module delay_line #(
    parameter int  DEPTH     = 1,
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     rst,
    input  payload_t in_data,
    output payload_t out_data
);

    // ----------------------------------------
    // register chain
    // ----------------------------------------

    // stage 0 takes the input and the last stage drives the output
    payload_t stages [DEPTH];

    always_ff @(posedge clock) begin
        if (rst) begin
            // clear every stage so that flags start inactive
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= in_data;
            // each stage takes the value of the one before it
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    // the payload appears DEPTH cycles after it entered
    assign out_data = stages[DEPTH-1];

endmodule

// File: hw/control_memory.sv
// ----------------------------------------
// control memory with one entry per aligned group
// each entry holds the block-end offset and target
// read is registered and loads come from outside
// ----------------------------------------

`timescale 1ns/1ps

module control_memory
    import cm_pkg::*;
#(
    parameter int GROUP_WIDTH = $bits(group_t),
    parameter int LSB_WIDTH   = $bits(lsb_t),
    parameter int PC_WIDTH    = $bits(pc_t)
) (
    input  logic                   clock,
    input  logic                   write,
    input  logic [GROUP_WIDTH-1:0] write_addr,
    input  logic [LSB_WIDTH-1:0]   write_match,
    input  logic [PC_WIDTH-1:0]    write_target,
    input  logic [GROUP_WIDTH-1:0] read_addr,
    output logic [LSB_WIDTH-1:0]   match,
    output logic [PC_WIDTH-1:0]    target
);

    localparam int ENTRIES = 2 ** GROUP_WIDTH;

    // match is an offset inside the group, so together with the group
    // index it names exactly one absolute address
    logic [LSB_WIDTH-1:0] match_mem  [ENTRIES];
    logic [PC_WIDTH-1:0]  target_mem [ENTRIES];

    // a bit per entry that turns to one on its first load
    logic [ENTRIES-1:0]   loaded;

    // ----------------------------------------
    // load port and registered read
    // ----------------------------------------

    // a read in the same cycle as a load returns the old entry
    always_ff @(posedge clock) begin
        if (write) begin
            match_mem[write_addr]  <= write_match;
            target_mem[write_addr] <= write_target;
            loaded[write_addr]     <= 1'b1;
        end
        match  <= match_mem[read_addr];
        target <= target_mem[read_addr];
    end

    // an entry that has been loaded must come out fully defined
    // on the cycle after its read
    read_defined: assert property (@(posedge clock)
        loaded[read_addr] === 1'b1 |=> !$isunknown({match, target}));

endmodule

// File: hw/basic_block_end.sv
// ----------------------------------------
// block-end comparator of the fetch unit
// compares registered low PC bits with the match
// value and delays the result to stages 2 and 3
// ----------------------------------------

`timescale 1ns/1ps

module basic_block_end
    import cm_pkg::*;
    import pipe_pkg::*;
#(
    parameter int LSB_WIDTH = $bits(lsb_t)
) (
    input  logic                 clock,
    input  logic                 rst,
    input  logic [LSB_WIDTH-1:0] pc_lsb,
    input  logic                 pc_valid,
    input  logic [LSB_WIDTH-1:0] match,
    output logic                 block_end_stage_2,
    output logic                 block_end_stage_3
);

    // valid bit on top of the low PC bits
    typedef logic [LSB_WIDTH:0] tagged_lsb_t;

    tagged_lsb_t          lsb_tagged_reg;
    logic                 pc_valid_reg;
    logic [LSB_WIDTH-1:0] pc_lsb_reg;
    logic                 block_end_raw;

    // ----------------------------------------
    // stage 0
    // ----------------------------------------

    // match already leaves the control memory registered once
    // so the PC bits need just one register to line up with it
    delay_line #(.DEPTH(1), .payload_t(tagged_lsb_t)) stage_0 (
        .clock    (clock),
        .rst      (rst),
        .in_data  ({pc_valid, pc_lsb}),
        .out_data (lsb_tagged_reg)
    );

    assign {pc_valid_reg, pc_lsb_reg} = lsb_tagged_reg;

    // held cycles never raise a flag since their valid bit is low
    assign block_end_raw = pc_valid_reg && (pc_lsb_reg == match);

    // ----------------------------------------
    // stages 1 to 3
    // ----------------------------------------

    delay_line #(.DEPTH(EARLY_DELAY), .payload_t(logic)) stages_1_2 (
        .clock    (clock),
        .rst      (rst),
        .in_data  (block_end_raw),
        .out_data (block_end_stage_2)
    );

    delay_line #(.DEPTH(1), .payload_t(logic)) stage_3 (
        .clock    (clock),
        .rst      (rst),
        .in_data  (block_end_stage_2),
        .out_data (block_end_stage_3)
    );

    // the final flag trails the compare by the distance from the match
    // stage to the final stage, across both flag lines
    final_follows_compare: assert property (@(posedge clock) disable iff (rst)
        block_end_stage_3 == $past(block_end_raw, FINAL_STAGE - MATCH_STAGE));

endmodule

// File: hw/pc_sequencer.sv
// ----------------------------------------
// program counter of the fetch unit
// steps through code while run is high and
// jumps to the target on a final block end
// ----------------------------------------

`timescale 1ns/1ps

module pc_sequencer
    import cm_pkg::*;
    import pipe_pkg::*;
#(
    parameter int PC_WIDTH = $bits(pc_t)
) (
    input  logic                clock,
    input  logic                rst,
    input  logic                run,
    input  logic                block_end,
    input  logic [PC_WIDTH-1:0] target,
    output logic [PC_WIDTH-1:0] pc,
    output logic                pc_valid
);

    typedef logic [PC_WIDTH-1:0] target_t;

    target_t target_final;

    // ----------------------------------------
    // target alignment
    // ----------------------------------------

    // the target comes out of the control memory with the match value
    // and has to wait until the flag reaches the final stage
    delay_line #(.DEPTH(TARGET_DELAY), .payload_t(target_t)) target_line (
        .clock    (clock),
        .rst      (rst),
        .in_data  (target),
        .out_data (target_final)
    );

    // ----------------------------------------
    // PC register
    // ----------------------------------------

    // pc_valid is run registered alongside the PC
    // an address counts as issued in a cycle where pc_valid is high,
    // so the PC moves past it only then and no address issues twice
    always_ff @(posedge clock) begin
        if (rst) begin
            pc       <= '0;
            pc_valid <= 1'b0;
        end else begin
            pc_valid <= run;
            if (block_end) begin
                // delay slots behind the block end have already issued
                pc <= target_final;
            end else if (pc_valid) begin
                // wraps around at the top of the address space
                pc <= pc + 1'b1;
            end
        end
    end

    // once run has been low, the PC holds unless a block end loads it
    pc_holds: assert property (@(posedge clock) disable iff (rst)
        !run ##1 !block_end |=> $stable(pc));

endmodule

// File: hw/block_end_top.sv
// ----------------------------------------
// top level of the block-end fetch unit
// ties the PC sequencer, the control memory and
// the block-end comparator together
// ----------------------------------------

`timescale 1ns/1ps

module block_end_top
    import cm_pkg::*;
#(
    parameter  int PC_WIDTH    = $bits(pc_t),
    parameter  int LSB_WIDTH   = $bits(lsb_t),
    localparam int GROUP_WIDTH = PC_WIDTH - LSB_WIDTH
) (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   run,

    // control memory load port
    input  logic                   cm_write,
    input  logic [GROUP_WIDTH-1:0] cm_addr,
    input  logic [LSB_WIDTH-1:0]   cm_match,
    input  logic [PC_WIDTH-1:0]    cm_target,

    output logic [PC_WIDTH-1:0]    pc,
    output logic                   block_end_early,
    output logic                   block_end
);

    logic                   pc_valid;
    logic [GROUP_WIDTH-1:0] pc_group;
    logic [LSB_WIDTH-1:0]   pc_lsb;
    logic [LSB_WIDTH-1:0]   match;
    logic [PC_WIDTH-1:0]    target;

    // ----------------------------------------
    // address split
    // ----------------------------------------

    // upper bits pick the group entry and low bits go to the compare
    assign pc_group = pc[PC_WIDTH-1:LSB_WIDTH];
    assign pc_lsb   = pc[LSB_WIDTH-1:0];

    // ----------------------------------------
    // instances
    // ----------------------------------------

    // the final flag loops back to load the branch target
    pc_sequencer #(.PC_WIDTH(PC_WIDTH)) pc_sequencer_inst (
        .clock     (clock),
        .rst       (rst),
        .run       (run),
        .block_end (block_end),
        .target    (target),
        .pc        (pc),
        .pc_valid  (pc_valid)
    );

    control_memory #(
        .GROUP_WIDTH (GROUP_WIDTH),
        .LSB_WIDTH   (LSB_WIDTH),
        .PC_WIDTH    (PC_WIDTH)
    ) control_memory_inst (
        .clock        (clock),
        .write        (cm_write),
        .write_addr   (cm_addr),
        .write_match  (cm_match),
        .write_target (cm_target),
        .read_addr    (pc_group),
        .match        (match),
        .target       (target)
    );

    // stage 2 gives the early flag and stage 3 the final one
    basic_block_end #(.LSB_WIDTH(LSB_WIDTH)) basic_block_end_inst (
        .clock             (clock),
        .rst               (rst),
        .pc_lsb            (pc_lsb),
        .pc_valid          (pc_valid),
        .match             (match),
        .block_end_stage_2 (block_end_early),
        .block_end_stage_3 (block_end)
    );

endmodule

// File: verif/block_end_model.svh
// ----------------------------------------
// cycle model of the block-end fetch unit
// included inside the testbench module, which
// imports cm_pkg and pipe_pkg for widths and stages
// ----------------------------------------

`ifndef BLOCK_END_MODEL_SVH
`define BLOCK_END_MODEL_SVH

localparam int MODEL_CYCLES = 512;

// control memory contents as the testbench loaded them
lsb_t mem_match  [2**GROUP_WIDTH];
pc_t  mem_target [2**GROUP_WIDTH];

// expected pc and issue bit for every cycle of the current row
pc_t  exp_pc     [MODEL_CYCLES];
bit   exp_issued [MODEL_CYCLES];

// an address issued in cycle t ends its block when its low bits
// equal the match value of its group
function automatic bit ends_block(int t);
    if (t < 0) begin
        return 1'b0;
    end
    return exp_issued[t] &&
        (exp_pc[t][LSB_WIDTH-1:0] == mem_match[exp_pc[t][PC_WIDTH-1:LSB_WIDTH]]);
endfunction

// flags trail the issue cycle by their stage number
function automatic bit early_flag(int n);
    return ends_block(n - EARLY_STAGE);
endfunction

function automatic bit final_flag(int n);
    return ends_block(n - FINAL_STAGE);
endfunction

// state right after reset and a load with run low
function automatic void clear_model();
    exp_pc[0]     = '0;
    exp_issued[0] = 1'b0;
endfunction

// works out cycle n+1 from cycle n and the run level driven in cycle n
function automatic void step_model(int n, bit run_level);
    exp_issued[n+1] = run_level;
    if (final_flag(n)) begin
        // target of the group that held the ending address
        exp_pc[n+1] = mem_target[exp_pc[n-FINAL_STAGE][PC_WIDTH-1:LSB_WIDTH]];
    end else if (exp_issued[n]) begin
        exp_pc[n+1] = exp_pc[n] + 1'b1;
    end else begin
        exp_pc[n+1] = exp_pc[n];
    end
endfunction

`endif

// File: verif/block_end_tb.sv
// ----------------------------------------
// testbench for the block-end fetch unit
// loads the control memory row by row from a table
// and checks every cycle against the cycle model
// ----------------------------------------

`timescale 1ns/1ps

module block_end_tb
    import cm_pkg::*;
    import pipe_pkg::*;
();

    localparam int CLOCK_PERIOD = 10;
    localparam int RESET_CYCLES = 5;
    localparam int GROUPS       = 2 ** GROUP_WIDTH;
    localparam int TESTS        = 6;

    // one row per test, with up to three directed entries
    typedef struct {
        string name;
        int    entries;
        int    group  [3];
        int    match  [3];
        int    target [3];
        int    run_low_from;
        int    run_low_to;
        int    cycles;
        bit    random_fill;
    } test_row_t;

    logic   clock;
    logic   rst;
    logic   run;
    logic   cm_write;
    group_t cm_addr;
    lsb_t   cm_match;
    pc_t    cm_target;
    pc_t    pc;
    logic   block_end_early;
    logic   block_end;

    test_row_t tests [TESTS];
    bit        table_ready = 1'b0;
    integer    seed = 32'ha91ebcf6;
    int        pass_count = 0;
    int        fail_count = 0;

`include "block_end_model.svh"

    block_end_top #(.PC_WIDTH(PC_WIDTH), .LSB_WIDTH(LSB_WIDTH)) block_end_top_inst (
        .clock           (clock),
        .rst             (rst),
        .run             (run),
        .cm_write        (cm_write),
        .cm_addr         (cm_addr),
        .cm_match        (cm_match),
        .cm_target       (cm_target),
        .pc              (pc),
        .block_end_early (block_end_early),
        .block_end       (block_end)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // the limit covers reset, load and run of every row plus a margin
    initial begin
        int limit;
        limit = 200;
        wait (table_ready);
        for (int i = 0; i < TESTS; i++) begin
            limit += RESET_CYCLES + GROUPS + tests[i].cycles + 1;
        end
        #(limit * CLOCK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ----------------------------------------
    // memory load
    // ----------------------------------------

    // unlisted groups end on their last word and fall through to the next group
    task automatic load_memory(input int r);
        for (int g = 0; g < GROUPS; g++) begin
            mem_match[g]  = '1;
            mem_target[g] = pc_t'(((g + 1) % GROUPS) << LSB_WIDTH);
            if (tests[r].random_fill) begin
                mem_match[g]  = lsb_t'($random(seed));
                mem_target[g] = pc_t'($random(seed));
            end
        end
        for (int e = 0; e < tests[r].entries; e++) begin
            mem_match[tests[r].group[e]]  = lsb_t'(tests[r].match[e]);
            mem_target[tests[r].group[e]] = pc_t'(tests[r].target[e]);
        end
        for (int g = 0; g < GROUPS; g++) begin
            cm_write  = 1'b1;
            cm_addr   = group_t'(g);
            cm_match  = mem_match[g];
            cm_target = mem_target[g];
            @(negedge clock);
        end
        cm_write = 1'b0;
    endtask

    // ----------------------------------------
    // one table row
    // ----------------------------------------

    task automatic run_test(input int r);
        int errors;
        bit run_level;
        errors = 0;
        rst    = 1'b1;
        run    = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;
        load_memory(r);
        clear_model();
        // outputs are sampled on the falling edge, where they are stable
        for (int n = 0; n < tests[r].cycles; n++) begin
            if (pc !== exp_pc[n]) begin
                $display("Error: pc = 0x%h, expected 0x%h (%s, cycle %0d)",
                    pc, exp_pc[n], tests[r].name, n);
                errors++;
            end
            if (block_end_early !== early_flag(n)) begin
                $display("Error: block_end_early = 0x%h, expected 0x%h (%s, cycle %0d)",
                    block_end_early, early_flag(n), tests[r].name, n);
                errors++;
            end
            if (block_end !== final_flag(n)) begin
                $display("Error: block_end = 0x%h, expected 0x%h (%s, cycle %0d)",
                    block_end, final_flag(n), tests[r].name, n);
                errors++;
            end
            run_level = !(n >= tests[r].run_low_from && n < tests[r].run_low_to);
            run       = run_level;
            step_model(n, run_level);
            @(negedge clock);
        end
        run = 1'b0;
        if (errors == 0) begin
            pass_count++;
            $display("%-22s pass", tests[r].name);
        end else begin
            fail_count++;
            $display("%-22s fail with %0d mismatches", tests[r].name, errors);
        end
    endtask

    initial begin
        rst       = 1'b1;
        run       = 1'b0;
        cm_write  = 1'b0;
        cm_addr   = '0;
        cm_match  = '0;
        cm_target = '0;
        // name, entries, groups, matches, targets, run low window, cycles, random
        tests[0] = '{"idle after reset", 0, '{0, 0, 0}, '{0, 0, 0}, '{0, 0, 0},
                     0, 40, 40, 1'b0};
        tests[1] = '{"single block end", 1, '{0, 0, 0}, '{5, 0, 0}, '{8'h40, 0, 0},
                     0, 0, 30, 1'b0};
        tests[2] = '{"absolute address", 1, '{3, 0, 0}, '{2, 0, 0}, '{8'h20, 0, 0},
                     0, 0, 80, 1'b0};
        // the end at 0x08 falls in the delay slots of the end at 0x06
        tests[3] = '{"back to back ends", 3, '{0, 1, 6}, '{6, 0, 1},
                     '{8'h50, 8'h30, 8'h60}, 0, 0, 60, 1'b0};
        // run drops while pc sits on the block-end address 0x05,
        // so only its one valid issue may raise the flags
        tests[4] = '{"run dropped", 1, '{0, 0, 0}, '{5, 0, 0}, '{8'h40, 0, 0},
                     5, 10, 40, 1'b0};
        tests[5] = '{"random table", 0, '{0, 0, 0}, '{0, 0, 0}, '{0, 0, 0},
                     0, 0, 300, 1'b1};
        table_ready = 1'b1;
        @(negedge clock);
        for (int r = 0; r < TESTS; r++) begin
            run_test(r);
        end
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
hw/cm_pkg.sv
hw/pipe_pkg.sv
hw/delay_line.sv
hw/control_memory.sv
hw/basic_block_end.sv
hw/pc_sequencer.sv
hw/block_end_top.sv
+incdir+verif
verif/block_end_tb.sv
